// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data bus geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int ADDR_W = 32;          // byte address width
  parameter int DATA_W = 32;          // one bus word
  parameter int BE_W   = DATA_W / 8;  // one enable per byte lane

  // bus and operand address
  typedef logic [ADDR_W-1:0] addr_t;

  // one data word, read or write
  typedef logic [DATA_W-1:0] word_t;

  // byte enables, bit n covers bits 8n+7..8n
  typedef logic [BE_W-1:0] be_t;

endpackage

// ==== lsu_op_pkg.sv ====
package lsu_op_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // access controls from the execute stage
  ////////////////////////////////////////////////////////////////////////////

  // access size, both byte codes act the same
  typedef enum logic [1:0] {
    SIZE_WORD     = 2'b00,
    SIZE_HALF     = 2'b01,
    SIZE_BYTE     = 2'b10,
    SIZE_BYTE_ALT = 2'b11
  } size_e;

  // load extension mode
  typedef enum logic [1:0] {
    EXT_ZERO     = 2'b00,  // upper bits cleared
    EXT_SIGN     = 2'b01,  // upper bits copy the lane msb
    EXT_ONES     = 2'b10,  // upper bits set
    EXT_SIGN_ALT = 2'b11   // same as EXT_SIGN
  } ext_e;

  // byte position inside a word
  typedef logic [1:0] offset_t;

endpackage

// ==== lsu_request_gen.sv ====
`timescale 1ns/1ps

module lsu_request_gen (
  input  logic                data_we_ex_i,
  input  lsu_op_pkg::size_e   data_type_ex_i,
  input  mem_bus_pkg::word_t  data_wdata_ex_i,
  input  lsu_op_pkg::offset_t data_reg_offset_ex_i,  // byte of the register holding lane 0
  input  logic                data_req_ex_i,
  input  mem_bus_pkg::addr_t  operand_a_ex_i,
  input  mem_bus_pkg::addr_t  operand_b_ex_i,
  input  logic                addr_useincr_ex_i,     // a + b, else a only
  input  logic                data_misaligned_ex_i,  // second phase of a split access
  output mem_bus_pkg::addr_t  trans_addr_o,
  output logic                trans_we_o,
  output mem_bus_pkg::be_t    trans_be_o,
  output mem_bus_pkg::word_t  trans_wdata_o,
  output lsu_op_pkg::offset_t addr_offset_o,
  output logic                data_misaligned_o
);

  mem_bus_pkg::addr_t  addr_int;      // full byte address
  lsu_op_pkg::offset_t wdata_offset;  // lane rotation for store data

  // address generation
  assign addr_int      = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_offset_o = addr_int[1:0];

  // second phase always starts at lane 0 of the next word
  assign trans_addr_o = data_misaligned_ex_i ? {addr_int[mem_bus_pkg::ADDR_W-1:2], 2'b00}
                                             : addr_int;
  assign trans_we_o   = data_we_ex_i;

  // split detection, only on a first phase
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (data_type_ex_i)
        lsu_op_pkg::SIZE_WORD: data_misaligned_o = (addr_int[1:0] != 2'b00);
        lsu_op_pkg::SIZE_HALF: data_misaligned_o = (addr_int[1:0] == 2'b11);
        default:               data_misaligned_o = 1'b0;  // bytes never cross
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    trans_be_o = 4'b0000;
    case (data_type_ex_i)
      lsu_op_pkg::SIZE_WORD: begin
        if (!data_misaligned_ex_i) begin
          case (addr_int[1:0])
            2'b00:   trans_be_o = 4'b1111;
            2'b01:   trans_be_o = 4'b1110;  // upper three lanes first
            2'b10:   trans_be_o = 4'b1100;
            default: trans_be_o = 4'b1000;
          endcase
        end else begin
          case (addr_int[1:0])  // remaining low lanes
            2'b01:   trans_be_o = 4'b0001;
            2'b10:   trans_be_o = 4'b0011;
            2'b11:   trans_be_o = 4'b0111;
            default: trans_be_o = 4'b0000;  // aligned word has no second phase
          endcase
        end
      end
      lsu_op_pkg::SIZE_HALF: begin
        if (!data_misaligned_ex_i) begin
          case (addr_int[1:0])
            2'b00:   trans_be_o = 4'b0011;
            2'b01:   trans_be_o = 4'b0110;
            2'b10:   trans_be_o = 4'b1100;
            default: trans_be_o = 4'b1000;  // low byte only, rest follows
          endcase
        end else begin
          trans_be_o = 4'b0001;  // high byte lands in lane 0
        end
      end
      default: begin
        case (addr_int[1:0])  // single byte lane
          2'b00:   trans_be_o = 4'b0001;
          2'b01:   trans_be_o = 4'b0010;
          2'b10:   trans_be_o = 4'b0100;
          default: trans_be_o = 4'b1000;
        endcase
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // store data placement
  //////////////////////////////////////////////////////////////////////////////

  // register byte r goes to lane (r + address offset - register offset)
  assign wdata_offset = addr_int[1:0] - data_reg_offset_ex_i;

  always_comb begin
    case (wdata_offset)
      2'b00:   trans_wdata_o = data_wdata_ex_i;
      2'b01:   trans_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'b10:   trans_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: trans_wdata_o = {data_wdata_ex_i[7:0], data_wdata_ex_i[31:8]};
    endcase
  end

endmodule

// ==== lsu_load_align.sv ====
`timescale 1ns/1ps

module lsu_load_align (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ctrl_update_i,         // EX hands its access over to WB
  input  lsu_op_pkg::size_e   data_type_ex_i,
  input  lsu_op_pkg::ext_e    data_sign_ext_ex_i,
  input  logic                data_we_ex_i,
  input  lsu_op_pkg::offset_t addr_offset_i,
  input  logic                data_misaligned_ex_i,  // second phase now in EX
  input  logic                data_misaligned_i,     // first phase of a split now in EX
  input  logic                resp_valid_i,
  input  mem_bus_pkg::word_t  resp_rdata_i,
  output mem_bus_pkg::word_t  data_rdata_ex_o
);

  // controls of the access waiting for its response
  lsu_op_pkg::size_e   data_type_q;
  lsu_op_pkg::ext_e    data_sign_ext_q;
  lsu_op_pkg::offset_t rdata_offset_q;
  logic                data_we_q;

  mem_bus_pkg::word_t  rdata_q;         // first-phase word or last result
  mem_bus_pkg::word_t  rdata_w_ext;
  mem_bus_pkg::word_t  rdata_h_ext;
  mem_bus_pkg::word_t  rdata_b_ext;
  mem_bus_pkg::word_t  data_rdata_ext;
  logic [15:0]         half_lane;
  logic [7:0]          byte_lane;
  logic                half_fill;
  logic                byte_fill;

  // value of the bits above the lane
  function automatic logic fill_bit(lsu_op_pkg::ext_e mode, logic msb);
    case (mode)
      lsu_op_pkg::EXT_ZERO: fill_bit = 1'b0;
      lsu_op_pkg::EXT_ONES: fill_bit = 1'b1;
      default:              fill_bit = msb;  // both sign codes
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q     <= lsu_op_pkg::SIZE_WORD;
      data_sign_ext_q <= lsu_op_pkg::EXT_ZERO;
      rdata_offset_q  <= '0;
      data_we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      data_type_q     <= data_type_ex_i;
      data_sign_ext_q <= data_sign_ext_ex_i;
      rdata_offset_q  <= addr_offset_i;
      data_we_q       <= data_we_ex_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////////////////////////////////

  // word, upper bytes of the held first phase fill the low part
  always_comb begin
    case (rdata_offset_q)
      2'b00:   rdata_w_ext = resp_rdata_i;
      2'b01:   rdata_w_ext = {resp_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w_ext = {resp_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w_ext = {resp_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (rdata_offset_q)
      2'b00:   half_lane = resp_rdata_i[15:0];
      2'b01:   half_lane = resp_rdata_i[23:8];
      2'b10:   half_lane = resp_rdata_i[31:16];
      default: half_lane = {resp_rdata_i[7:0], rdata_q[31:24]};  // split halfword
    endcase
  end

  always_comb begin
    case (rdata_offset_q)
      2'b00:   byte_lane = resp_rdata_i[7:0];
      2'b01:   byte_lane = resp_rdata_i[15:8];
      2'b10:   byte_lane = resp_rdata_i[23:16];
      default: byte_lane = resp_rdata_i[31:24];
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // extension and result
  //////////////////////////////////////////////////////////////////////////////

  assign half_fill   = fill_bit(data_sign_ext_q, half_lane[15]);
  assign byte_fill   = fill_bit(data_sign_ext_q, byte_lane[7]);
  assign rdata_h_ext = {{16{half_fill}}, half_lane};
  assign rdata_b_ext = {{24{byte_fill}}, byte_lane};

  always_comb begin
    case (data_type_q)
      lsu_op_pkg::SIZE_WORD: data_rdata_ext = rdata_w_ext;
      lsu_op_pkg::SIZE_HALF: data_rdata_ext = rdata_h_ext;
      default:               data_rdata_ext = rdata_b_ext;
    endcase
  end

  // raw word while a split load is in progress, else the finished result
  always_ff @(posedge clk) begin
    if (resp_valid_i && !data_we_q) begin
      if (data_misaligned_ex_i || data_misaligned_i) begin
        rdata_q <= resp_rdata_i;
      end else begin
        rdata_q <= data_rdata_ext;
      end
    end
  end

  assign data_rdata_ex_o = resp_valid_i ? data_rdata_ext : rdata_q;  // hold between loads

endmodule

// ==== lsu_txn_ctrl.sv ====
`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int DEPTH = 2  // max outstanding transactions
) (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic trans_req_o,
  output logic ctrl_update_o,
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH);

  logic [CNT_W-1:0] cnt_q;       // transactions granted, response pending
  logic [CNT_W-1:0] next_cnt;
  logic             count_up;    // request accepted this cycle
  logic             count_down;  // response arrives this cycle
  logic             accepted;

  // no request leaves while the pipe is full
  assign trans_req_o = data_req_ex_i && (cnt_q < CNT_MAX);
  assign accepted    = trans_req_o && data_gnt_i;

  //////////////////////////////////////////////////////////////////////////////
  // stage readiness
  //////////////////////////////////////////////////////////////////////////////

  // WB is free when empty, or its response is here
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB advance together once WB is occupied
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;
    end else if (cnt_q == '0) begin
      lsu_ready_ex_o = accepted;
    end else if (cnt_q < CNT_MAX) begin
      lsu_ready_ex_o = data_rvalid_i && accepted;
    end else begin
      lsu_ready_ex_o = data_rvalid_i;  // request already granted earlier
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o        = (cnt_q != '0) || trans_req_o;

  //////////////////////////////////////////////////////////////////////////////
  // outstanding counter
  //////////////////////////////////////////////////////////////////////////////

  assign count_up   = accepted;
  assign count_down = data_rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= next_cnt;
    end
  end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
  parameter int DEPTH = 2  // outstanding bus transactions
) (
  input  logic                clk,
  input  logic                rst_n,

  // execute stage
  input  logic                data_we_ex_i,
  input  lsu_op_pkg::size_e   data_type_ex_i,
  input  mem_bus_pkg::word_t  data_wdata_ex_i,
  input  lsu_op_pkg::offset_t data_reg_offset_ex_i,
  input  logic                data_req_ex_i,
  input  mem_bus_pkg::addr_t  operand_a_ex_i,
  input  mem_bus_pkg::addr_t  operand_b_ex_i,
  input  logic                addr_useincr_ex_i,
  input  logic                data_misaligned_ex_i,
  input  lsu_op_pkg::ext_e    data_sign_ext_ex_i,

  // data bus
  output logic                data_req_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  output mem_bus_pkg::addr_t  data_addr_o,
  output logic                data_we_o,
  output mem_bus_pkg::be_t    data_be_o,
  output mem_bus_pkg::word_t  data_wdata_o,
  input  mem_bus_pkg::word_t  data_rdata_i,

  // back to the pipeline
  output mem_bus_pkg::word_t  data_rdata_ex_o,
  output logic                data_misaligned_o,
  output logic                lsu_ready_ex_o,
  output logic                lsu_ready_wb_o,
  output logic                busy_o
);

  logic                ctrl_update;  // EX access moves to WB
  lsu_op_pkg::offset_t addr_offset;

  ////////////////////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////////////////////

  lsu_request_gen i_request_gen (
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .data_req_ex_i        (data_req_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .trans_addr_o         (data_addr_o),
    .trans_we_o           (data_we_o),
    .trans_be_o           (data_be_o),
    .trans_wdata_o        (data_wdata_o),
    .addr_offset_o        (addr_offset),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_txn_ctrl #(
    .DEPTH (DEPTH)
  ) i_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .trans_req_o    (data_req_o),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // response phase
  ////////////////////////////////////////////////////////////////////////////

  lsu_load_align i_load_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .addr_offset_i        (addr_offset),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .resp_valid_i         (data_rvalid_i),
    .resp_rdata_i         (data_rdata_i),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

// ==== tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top;

  // one row of the stimulus table
  typedef struct packed {
    logic                we;
    lsu_op_pkg::size_e   size;
    lsu_op_pkg::ext_e    ext;
    mem_bus_pkg::addr_t  op_a;
    mem_bus_pkg::addr_t  op_b;
    logic                incr;      // a + b
    mem_bus_pkg::word_t  wdata;
    lsu_op_pkg::offset_t reg_off;
    mem_bus_pkg::be_t    be;        // first phase
    logic                mis;       // split access expected
    mem_bus_pkg::word_t  data;      // load result or first memory word after a store
    mem_bus_pkg::word_t  data2;     // second memory word of a split store
  } entry_t;

  logic                clk;
  logic                rst_n;
  logic                data_we_ex_i;
  lsu_op_pkg::size_e   data_type_ex_i;
  mem_bus_pkg::word_t  data_wdata_ex_i;
  lsu_op_pkg::offset_t data_reg_offset_ex_i;
  logic                data_req_ex_i;
  mem_bus_pkg::addr_t  operand_a_ex_i;
  mem_bus_pkg::addr_t  operand_b_ex_i;
  logic                addr_useincr_ex_i;
  logic                data_misaligned_ex_i;
  lsu_op_pkg::ext_e    data_sign_ext_ex_i;
  logic                data_gnt_i = 1'b0;
  logic                data_rvalid_i = 1'b0;
  mem_bus_pkg::word_t  data_rdata_i = '0;
  logic                data_req_o;
  mem_bus_pkg::addr_t  data_addr_o;
  logic                data_we_o;
  mem_bus_pkg::be_t    data_be_o;
  mem_bus_pkg::word_t  data_wdata_o;
  mem_bus_pkg::word_t  data_rdata_ex_o;
  logic                data_misaligned_o;
  logic                lsu_ready_ex_o;
  logic                lsu_ready_wb_o;
  logic                busy_o;

  entry_t             tbl[$];
  string              names[$];
  mem_bus_pkg::word_t mem [16];     // 64 bytes of bus memory
  mem_bus_pkg::word_t pend_data[$]; // granted with response pending
  int                 pend_due[$];  // cycle of earliest response
  logic [31:0]        lfsr_q;
  int                 now_cyc;
  int                 grant_cnt;
  int                 errors;
  int                 checks;
  int                 limit;
  logic               hold_resp;    // withhold all responses
  logic               force_gnt;
  logic               table_done;

  lsu_top #(.DEPTH(2)) i_lsu_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [3:0] widx;
    logic [1:0] r;
    int         dly;
    if (!rst_n) begin
      for (int a = 0; a < 64; a++) begin
        mem[a / 4][8 * (a % 4) +: 8] = {2'(a), 6'(a)};  // byte value from its address
      end
      lfsr_q        = 32'hf6db_52e9;
      now_cyc       = 0;
      grant_cnt     = 0;
      pend_data.delete();
      pend_due.delete();
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
    end else begin
      if (data_rvalid_i) begin  // response taken this cycle
        void'(pend_data.pop_front());
        void'(pend_due.pop_front());
      end
      if (data_req_o && data_gnt_i) begin
        widx = data_addr_o[5:2];
        if (data_we_o) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_o[b]) mem[widx][8 * b +: 8] = data_wdata_o[8 * b +: 8];
          end
        end
        r   = {next_bit(), next_bit()};
        dly = (r == 2'b00) ? 1 : int'(r);  // 1 to 3 cycles
        pend_data.push_back(mem[widx]);
        pend_due.push_back(now_cyc + dly - 1);
        grant_cnt++;
      end
      data_gnt_i <= force_gnt | next_bit() | next_bit();
      if (pend_data.size() > 0 && !hold_resp && pend_due[0] <= now_cyc) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= pend_data[0];
      end else begin
        data_rvalid_i <= 1'b0;
        data_rdata_i  <= '0;
      end
      now_cyc++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input mem_bus_pkg::word_t exp_v,
                            input mem_bus_pkg::word_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", what, exp_v, act_v);
    end
  endtask

  task automatic check_be(input string what, input mem_bus_pkg::be_t exp_v,
                          input mem_bus_pkg::be_t act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", what, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string what, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", what, exp_v, act_v);
    end
  endtask

  task automatic add_entry(input string nm, input logic we, input lsu_op_pkg::size_e sz,
                           input lsu_op_pkg::ext_e ext, input logic [31:0] a,
                           input logic [31:0] b, input logic incr, input logic [31:0] wd,
                           input logic [1:0] roff, input logic [3:0] be, input logic mis,
                           input logic [31:0] d, input logic [31:0] d2);
    tbl.push_back({we, sz, ext, a, b, incr, wd, roff, be, mis, d, d2});
    names.push_back(nm);
  endtask

  task automatic fill_table();
    // loads from words 0..4 where memory stays untouched
    add_entry("ld word 0", 0, lsu_op_pkg::SIZE_WORD, lsu_op_pkg::EXT_ZERO,
              0, 0, 0, 0, 0, 4'b1111, 0, 32'hc382_4100, 0);
    add_entry("ld half 2 zero", 0, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_ZERO,
              0, 2, 1, 0, 0, 4'b1100, 0, 32'h0000_c382, 0);
    add_entry("ld half 1 sign", 0, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_SIGN,
              1, 0, 0, 0, 0, 4'b0110, 0, 32'hffff_8241, 0);
    add_entry("ld half 4 ones", 0, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_ONES,
              4, 0, 0, 0, 0, 4'b0011, 0, 32'hffff_4504, 0);
    add_entry("ld byte 5 sign", 0, lsu_op_pkg::SIZE_BYTE, lsu_op_pkg::EXT_SIGN,
              5, 0, 0, 0, 0, 4'b0010, 0, 32'h0000_0045, 0);
    add_entry("ld byte 7 sign alt", 0, lsu_op_pkg::SIZE_BYTE_ALT, lsu_op_pkg::EXT_SIGN_ALT,
              4, 3, 1, 0, 0, 4'b1000, 0, 32'hffff_ffc7, 0);
    add_entry("ld byte 6 zero", 0, lsu_op_pkg::SIZE_BYTE, lsu_op_pkg::EXT_ZERO,
              6, 0, 0, 0, 0, 4'b0100, 0, 32'h0000_0086, 0);
    add_entry("ld byte 8 ones", 0, lsu_op_pkg::SIZE_BYTE, lsu_op_pkg::EXT_ONES,
              8, 0, 0, 0, 0, 4'b0001, 0, 32'hffff_ff08, 0);
    add_entry("ld word 1 split", 0, lsu_op_pkg::SIZE_WORD, lsu_op_pkg::EXT_ZERO,
              1, 0, 0, 0, 0, 4'b1110, 1, 32'h04c3_8241, 0);
    add_entry("ld word 6 split", 0, lsu_op_pkg::SIZE_WORD, lsu_op_pkg::EXT_ZERO,
              4, 2, 1, 0, 0, 4'b1100, 1, 32'h4908_c786, 0);
    add_entry("ld word b split", 0, lsu_op_pkg::SIZE_WORD, lsu_op_pkg::EXT_SIGN,
              32'hb, 0, 0, 0, 0, 4'b1000, 1, 32'h8e4d_0ccb, 0);
    add_entry("ld half 3 split", 0, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_SIGN,
              3, 0, 0, 0, 0, 4'b1000, 1, 32'h0000_04c3, 0);
    add_entry("ld half f split", 0, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_SIGN_ALT,
              32'hf, 0, 0, 0, 0, 4'b1000, 1, 32'h0000_10cf, 0);
    // stores into words 5..15
    add_entry("st word 20", 1, lsu_op_pkg::SIZE_WORD, lsu_op_pkg::EXT_ZERO,
              32'h20, 0, 0, 32'h1122_3344, 0, 4'b1111, 0, 32'h1122_3344, 0);
    add_entry("st half 26", 1, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_ZERO,
              32'h24, 2, 1, 32'h0000_beef, 0, 4'b1100, 0, 32'hbeef_6524, 0);
    add_entry("st byte 29", 1, lsu_op_pkg::SIZE_BYTE, lsu_op_pkg::EXT_ZERO,
              32'h29, 0, 0, 32'h0000_00a5, 0, 4'b0010, 0, 32'hebaa_a528, 0);
    add_entry("st byte 2f regoff 3", 1, lsu_op_pkg::SIZE_BYTE, lsu_op_pkg::EXT_ZERO,
              32'h2f, 0, 0, 32'h5a00_0000, 3, 4'b1000, 0, 32'h5aae_6d2c, 0);
    add_entry("st half 31", 1, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_ZERO,
              32'h31, 0, 0, 32'h0000_7e81, 0, 4'b0110, 0, 32'hf37e_8130, 0);
    add_entry("st byte 36 regoff 1", 1, lsu_op_pkg::SIZE_BYTE_ALT, lsu_op_pkg::EXT_ZERO,
              32'h36, 0, 0, 32'h0000_c300, 1, 4'b0100, 0, 32'hf7c3_7534, 0);
    add_entry("st half 14", 1, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_ZERO,
              32'h10, 4, 1, 32'h0000_9c3d, 0, 4'b0011, 0, 32'hd796_9c3d, 0);
    // register byte 2 wraps around to lane 0
    add_entry("st byte 24 regoff 2", 1, lsu_op_pkg::SIZE_BYTE, lsu_op_pkg::EXT_ZERO,
              32'h24, 0, 0, 32'h00e7_0000, 2, 4'b0001, 0, 32'hbeef_65e7, 0);
    add_entry("st word 39 split", 1, lsu_op_pkg::SIZE_WORD, lsu_op_pkg::EXT_ZERO,
              32'h39, 0, 0, 32'ha1b2_c3d4, 0, 4'b1110, 1, 32'hb2c3_d438, 32'hffbe_7da1);
    add_entry("st half 1b split", 1, lsu_op_pkg::SIZE_HALF, lsu_op_pkg::EXT_ZERO,
              32'h1b, 0, 0, 32'h0000_6655, 0, 4'b1000, 1, 32'h559a_5918, 32'hdf9e_5d66);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // execute-stage driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_entry(input int idx);
    entry_t             e;
    string              nm;
    mem_bus_pkg::addr_t baddr;
    mem_bus_pkg::be_t   be2;
    mem_bus_pkg::word_t res;
    e     = tbl[idx];
    nm    = names[idx];
    baddr = e.incr ? e.op_a + e.op_b : e.op_a;
    @(posedge clk);
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= e.we;
    data_type_ex_i       <= e.size;
    data_sign_ext_ex_i   <= e.ext;
    operand_a_ex_i       <= e.op_a;
    operand_b_ex_i       <= e.op_b;
    addr_useincr_ex_i    <= e.incr;
    data_wdata_ex_i      <= e.wdata;
    data_reg_offset_ex_i <= e.reg_off;
    data_misaligned_ex_i <= 1'b0;
    @(negedge clk);
    check_bit({nm, " req"}, 1'b1, data_req_o);  // nothing outstanding yet
    check_bit({nm, " we"}, e.we, data_we_o);
    check_word({nm, " addr"}, baddr, data_addr_o);
    check_be({nm, " be"}, e.be, data_be_o);
    check_bit({nm, " misaligned"}, e.mis, data_misaligned_o);
    while (!lsu_ready_ex_o) @(negedge clk);  // grant pending
    @(posedge clk);
    if (e.mis) begin
      // second phase at the same byte offset in the next word
      data_misaligned_ex_i <= 1'b1;
      operand_a_ex_i       <= baddr + 4;
      addr_useincr_ex_i    <= 1'b0;
      be2 = (e.size == lsu_op_pkg::SIZE_WORD) ? ((4'b0001 << baddr[1:0]) - 4'b0001) : 4'b0001;
      @(negedge clk);
      check_word({nm, " addr2"}, {baddr[31:2] + 30'd1, 2'b00}, data_addr_o);
      check_be({nm, " be2"}, be2, data_be_o);
      while (!lsu_ready_ex_o) @(negedge clk);
      @(posedge clk);
    end
    data_req_ex_i        <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
    res = '0;
    do begin
      @(negedge clk);
      if (data_rvalid_i) res = data_rdata_ex_o;  // final response cycle
    end while (busy_o);
    if (!e.we) begin
      check_word({nm, " data"}, e.data, res);
      check_word({nm, " held"}, e.data, data_rdata_ex_o);  // no response this cycle
    end else begin
      check_word({nm, " mem"}, e.data, mem[baddr[5:2]]);
      if (e.mis) check_word({nm, " mem2"}, e.data2, mem[baddr[5:2] + 4'd1]);
    end
  endtask

  // responses held back while grants are forced
  task automatic run_burst();
    int base;
    @(posedge clk);
    hold_resp <= 1'b1;
    force_gnt <= 1'b1;
    base = grant_cnt;
    @(posedge clk);
    data_req_ex_i     <= 1'b1;
    data_we_ex_i      <= 1'b0;
    data_type_ex_i    <= lsu_op_pkg::SIZE_WORD;
    operand_a_ex_i    <= '0;
    addr_useincr_ex_i <= 1'b0;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_bit("burst busy", 1'b1, busy_o);
      if (i > 0) check_bit("burst wb ready", 1'b0, lsu_ready_wb_o);
    end
    @(posedge clk);
    data_req_ex_i <= 1'b0;
    hold_resp     <= 1'b0;
    force_gnt     <= 1'b0;
    @(negedge clk);
    check_word("burst grants", 32'd2, mem_bus_pkg::word_t'(grant_cnt - base));
    while (busy_o) begin
      check_bit("drain wb ready", data_rvalid_i, lsu_ready_wb_o);
      @(negedge clk);
    end
    check_bit("idle wb ready", 1'b1, lsu_ready_wb_o);
    check_bit("idle ex ready", 1'b1, lsu_ready_ex_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    errors = 0;
    checks = 0;
    hold_resp = 1'b0;
    force_gnt = 1'b0;
    table_done = 1'b0;
    rst_n = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = lsu_op_pkg::SIZE_WORD;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = '0;
    data_req_ex_i = 1'b0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    data_sign_ext_ex_i = lsu_op_pkg::EXT_ZERO;
    fill_table();
    limit = 30 * tbl.size() + 100;
    table_done = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("reset req", 1'b0, data_req_o);
    check_bit("reset busy", 1'b0, busy_o);
    check_bit("reset wb ready", 1'b1, lsu_ready_wb_o);
    check_bit("reset ex ready", 1'b1, lsu_ready_ex_o);
    for (int i = 0; i < tbl.size(); i++) run_entry(i);
    run_burst();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    int cyc;
    cyc = 0;
    wait (table_done);
    while (cyc <= limit) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout after %0d cycles, the LSU stopped answering", cyc);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
mem_bus_pkg.sv
lsu_op_pkg.sv
lsu_request_gen.sv
lsu_load_align.sv
lsu_txn_ctrl.sv
lsu_top.sv
tb_lsu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_lsu_top -o sim_lsu
./obj_dir/sim_lsu | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
